// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_controller \
		-f controller.f -o tb_controller
	./obj_dir/tb_controller | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cnt_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnt_ram
    import ctl_pkg::*;
(
    input  wire            CLK,
    input  wire            host_we,
    input  wire cnt_addr_t host_addr,
    input  wire word_t     host_wdata,
    output word_t          host_rdata,
    input  wire cnt_req_t  req,
    output word_t          cnt_dout
);

    word_t mem [2**$bits(cnt_addr_t)];

    // first read stage of each port
    word_t host_rd_q;
    word_t cnt_rd_q;

    always_ff @(posedge CLK) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        // controller write comes last so it wins a same-address collision
        if (req.we) begin
            mem[req.addr] <= req.din;
        end
    end

    always_ff @(posedge CLK) begin
        host_rd_q  <= mem[host_addr];
        host_rdata <= host_rd_q;
        cnt_rd_q   <= mem[req.addr];
        cnt_dout   <= cnt_rd_q;
    end

endmodule

`default_nettype wire

// ==== controller.f ====
ctl_pkg.sv
cnt_ram.sv
settings_loader.sv
settings_regs.sv
ctl_sequencer.sv
controller_top.sv
controller_asserts.sv
tb_controller.sv

// ==== controller_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller_asserts (
    input wire CLK,
    input wire rst,
    input wire req_we,
    input wire load_start,
    input wire load_done,
    input wire mod_update,
    input wire silencer_update
);

    // high from load_start until load_done
    logic load_active;

    always_ff @(posedge CLK) begin
        if (rst) begin
            load_active <= 1'b0;
        end else if (load_start) begin
            load_active <= 1'b1;
        end else if (load_done) begin
            load_active <= 1'b0;
        end
    end

    mod_update_single: assert property (@(posedge CLK) disable iff (rst)
        !(mod_update && $past(mod_update)))
        else $error("mod update high for two cycles");

    silencer_update_single: assert property (@(posedge CLK) disable iff (rst)
        !(silencer_update && $past(silencer_update)))
        else $error("silencer update high for two cycles");

    start_while_idle: assert property (@(posedge CLK) disable iff (rst)
        load_start |-> !load_active)
        else $error("load_start during an active load");

    no_write_during_load: assert property (@(posedge CLK) disable iff (rst)
        load_active |-> !req_we)
        else $error("controller port write during a load");

endmodule

bind controller_top controller_asserts asserts0 (
    .CLK             (CLK),
    .rst             (rst),
    .req_we          (req.we),
    .load_start      (load_start),
    .load_done       (load_done),
    .mod_update      (mod_settings.update),
    .silencer_update (silencer_settings.update)
);

`default_nettype wire

// ==== controller_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller_top
    import ctl_pkg::*;
#(
    parameter int BURST_LEN = MAX_BURST
) (
    input  wire            CLK,
    input  wire            rst,
    input  wire            thermo,
    input  wire            mod_segment,
    input  wire            host_we,
    input  wire cnt_addr_t host_addr,
    input  wire word_t     host_wdata,
    output word_t          host_rdata,
    output mod_settings_t      mod_settings,
    output silencer_settings_t silencer_settings,
    output logic           force_fan,
    output gpio_t          gpio_in
);

    cnt_req_t   req;
    cnt_req_t   loader_req;
    word_t      cnt_dout;
    logic       load_start;
    cnt_addr_t  load_base;
    burst_cnt_t load_count;
    logic       load_done;
    word_t      load_words [BURST_LEN];
    logic       commit_mod;
    logic       commit_silencer;

    cnt_ram ram0 (
        .CLK        (CLK),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .req        (req),
        .cnt_dout   (cnt_dout)
    );

    ctl_sequencer seq0 (
        .CLK             (CLK),
        .rst             (rst),
        .thermo          (thermo),
        .mod_segment     (mod_segment),
        .cnt_dout        (cnt_dout),
        .loader_req      (loader_req),
        .load_done       (load_done),
        .req             (req),
        .load_start      (load_start),
        .load_base       (load_base),
        .load_count      (load_count),
        .commit_mod      (commit_mod),
        .commit_silencer (commit_silencer),
        .force_fan       (force_fan),
        .gpio_in         (gpio_in)
    );

    settings_loader #(
        .BURST_LEN (BURST_LEN)
    ) loader0 (
        .CLK        (CLK),
        .rst        (rst),
        .load_start (load_start),
        .load_base  (load_base),
        .load_count (load_count),
        .cnt_dout   (cnt_dout),
        .req        (loader_req),
        .load_done  (load_done),
        .load_words (load_words)
    );

    settings_regs #(
        .BURST_LEN (BURST_LEN)
    ) regs0 (
        .CLK               (CLK),
        .rst               (rst),
        .commit_mod        (commit_mod),
        .commit_silencer   (commit_silencer),
        .load_words        (load_words),
        .mod_settings      (mod_settings),
        .silencer_settings (silencer_settings)
    );

endmodule

`default_nettype wire

// ==== ctl_pkg.sv ====
`default_nettype none

package ctl_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  cnt_addr_t;
    // length of one settings burst, in words
    typedef logic [3:0]  burst_cnt_t;
    typedef logic [3:0]  gpio_t;

    typedef struct packed {
        logic      we;
        cnt_addr_t addr;
        word_t     din;
    } cnt_req_t;

    localparam cnt_addr_t ADDR_VERSION_NUM_MINOR = 8'h00;
    localparam cnt_addr_t ADDR_VERSION_NUM_MAJOR = 8'h01;
    localparam cnt_addr_t ADDR_CTL_FLAG          = 8'h02;
    localparam cnt_addr_t ADDR_FPGA_STATE        = 8'h03;

    // settings blocks sit at consecutive addresses
    localparam cnt_addr_t ADDR_MOD_BASE      = 8'h20;
    localparam int        MOD_WORDS          = 12;
    localparam cnt_addr_t ADDR_SILENCER_BASE = 8'h40;
    localparam int        SILENCER_WORDS     = 5;
    localparam int        MAX_BURST          = 12;

    localparam int CTL_FLAG_BIT_MOD_SET      = 0;
    localparam int CTL_FLAG_BIT_SILENCER_SET = 1;
    localparam int CTL_FLAG_BIT_FORCE_FAN    = 4;
    // gpio occupies bits 8 to 11
    localparam int CTL_FLAG_BIT_GPIO_IN_0    = 8;

    localparam int FPGA_STATE_BIT_THERMO      = 0;
    localparam int FPGA_STATE_BIT_MOD_SEGMENT = 1;

    localparam logic [7:0] VERSION_NUM_MAJOR = 8'hA5;
    localparam logic [7:0] VERSION_NUM_MINOR = 8'h03;

    localparam logic SILENCER_MODE_FIXED_COMPLETION_STEPS = 1'b1;

    typedef struct packed {
        logic        update;
        logic        req_rd_segment;
        logic [7:0]  transition_mode;
        logic [63:0] transition_value;
        logic [14:0] cycle0;
        logic [14:0] cycle1;
        logic [15:0] freq_div0;
        logic [15:0] freq_div1;
        logic [15:0] rep0;
        logic [15:0] rep1;
    } mod_settings_t;

    typedef struct packed {
        logic       update;
        logic       mode;
        logic [7:0] update_rate_intensity;
        logic [7:0] update_rate_phase;
        logic [7:0] completion_steps_intensity;
        logic [7:0] completion_steps_phase;
    } silencer_settings_t;

    localparam mod_settings_t MOD_DEFAULTS = '{
        update:           1'b0,
        req_rd_segment:   1'b0,
        transition_mode:  8'd0,
        transition_value: 64'd0,
        cycle0:           15'd1,
        cycle1:           15'd1,
        freq_div0:        16'd10,
        freq_div1:        16'd10,
        rep0:             16'hFFFF,
        rep1:             16'hFFFF
    };

    localparam silencer_settings_t SILENCER_DEFAULTS = '{
        update:                     1'b0,
        mode:                       SILENCER_MODE_FIXED_COMPLETION_STEPS,
        update_rate_intensity:      8'd1,
        update_rate_phase:          8'd1,
        completion_steps_intensity: 8'd10,
        completion_steps_phase:     8'd40
    };

endpackage

`default_nettype wire

// ==== ctl_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctl_sequencer
    import ctl_pkg::*;
(
    input  wire           CLK,
    input  wire           rst,
    input  wire           thermo,
    input  wire           mod_segment,
    input  wire word_t    cnt_dout,
    input  wire cnt_req_t loader_req,
    input  wire           load_done,
    output cnt_req_t      req,
    output logic          load_start,
    output cnt_addr_t     load_base,
    output burst_cnt_t    load_count,
    output logic          commit_mod,
    output logic          commit_silencer,
    output logic          force_fan,
    output gpio_t         gpio_in
);

    typedef enum logic [2:0] {
        VERSION_MINOR,
        VERSION_MAJOR,
        POLL_REQ,
        POLL_WAIT,
        POLL_EVAL,
        LOAD,
        WRITE_FLAGS,
        COMMIT
    } state_t;

    state_t state;
    word_t  ctl_flags;
    word_t  fpga_state;
    logic   sel_mod;
    logic   mod_set;
    logic   silencer_set;

    // valid only in POLL_EVAL, two edges after the flag read
    assign mod_set      = cnt_dout[CTL_FLAG_BIT_MOD_SET];
    assign silencer_set = cnt_dout[CTL_FLAG_BIT_SILENCER_SET];

    always_comb begin
        fpga_state = '0;
        fpga_state[FPGA_STATE_BIT_THERMO]      = thermo;
        fpga_state[FPGA_STATE_BIT_MOD_SEGMENT] = mod_segment;
    end

    // port request follows the state
    always_comb begin
        req = '{we: 1'b0, addr: ADDR_CTL_FLAG, din: '0};
        case (state)
            VERSION_MINOR: begin
                req = '{we: 1'b1, addr: ADDR_VERSION_NUM_MINOR,
                        din: {8'h00, VERSION_NUM_MINOR}};
            end
            VERSION_MAJOR: begin
                req = '{we: 1'b1, addr: ADDR_VERSION_NUM_MAJOR,
                        din: {8'h00, VERSION_NUM_MAJOR}};
            end
            POLL_WAIT: req = '{we: 1'b1, addr: ADDR_FPGA_STATE, din: fpga_state};
            LOAD: req = loader_req;
            WRITE_FLAGS: req = '{we: 1'b1, addr: ADDR_CTL_FLAG, din: ctl_flags};
            default: ;
        endcase
    end

    // modulation wins when both are set
    assign load_start = (state == POLL_EVAL) && (mod_set || silencer_set);
    assign load_base  = mod_set ? ADDR_MOD_BASE : ADDR_SILENCER_BASE;
    assign load_count = mod_set ? burst_cnt_t'(MOD_WORDS) : burst_cnt_t'(SILENCER_WORDS);

    assign commit_mod      = (state == COMMIT) && sel_mod;
    assign commit_silencer = (state == COMMIT) && !sel_mod;

    assign force_fan = ctl_flags[CTL_FLAG_BIT_FORCE_FAN];
    assign gpio_in   = ctl_flags[CTL_FLAG_BIT_GPIO_IN_0 +: $bits(gpio_t)];

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= VERSION_MINOR;
            ctl_flags <= '0;
            sel_mod   <= 1'b0;
        end else begin
            case (state)
                VERSION_MINOR: state <= VERSION_MAJOR;
                VERSION_MAJOR: state <= POLL_REQ;
                POLL_REQ:      state <= POLL_WAIT;
                POLL_WAIT:     state <= POLL_EVAL;
                POLL_EVAL: begin
                    ctl_flags <= cnt_dout;
                    if (mod_set) begin
                        ctl_flags[CTL_FLAG_BIT_MOD_SET] <= 1'b0;
                        sel_mod <= 1'b1;
                        state   <= LOAD;
                    end else if (silencer_set) begin
                        ctl_flags[CTL_FLAG_BIT_SILENCER_SET] <= 1'b0;
                        sel_mod <= 1'b0;
                        state   <= LOAD;
                    end else begin
                        state <= POLL_REQ;
                    end
                end
                LOAD: begin
                    if (load_done) begin
                        state <= WRITE_FLAGS;
                    end
                end
                // cleared flags reach memory before the update pulse
                WRITE_FLAGS: state <= COMMIT;
                COMMIT:      state <= POLL_REQ;
                default:     state <= POLL_REQ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== settings_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module settings_loader
    import ctl_pkg::*;
#(
    parameter int BURST_LEN = MAX_BURST
) (
    input  wire             CLK,
    input  wire             rst,
    input  wire             load_start,
    input  wire cnt_addr_t  load_base,
    input  wire burst_cnt_t load_count,
    input  wire word_t      cnt_dout,
    output cnt_req_t        req,
    output logic            load_done,
    output word_t           load_words [BURST_LEN]
);

    cnt_addr_t  rd_addr;
    burst_cnt_t count_q;
    burst_cnt_t issue_cnt;
    burst_cnt_t capture_cnt;
    logic       issuing;
    // one bit per read stage of the RAM
    logic [1:0] rd_valid;

    assign req = '{we: 1'b0, addr: rd_addr, din: '0};

    always_ff @(posedge CLK) begin
        if (rst) begin
            issuing     <= 1'b0;
            rd_valid    <= '0;
            issue_cnt   <= '0;
            capture_cnt <= '0;
            count_q     <= '0;
            load_done   <= 1'b0;
        end else begin
            rd_valid  <= {rd_valid[0], issuing};
            load_done <= 1'b0;
            if (load_start) begin
                issuing     <= load_count != '0;
                issue_cnt   <= 4'd1;
                capture_cnt <= '0;
                count_q     <= load_count;
            end else if (issuing) begin
                if (issue_cnt == count_q) begin
                    issuing <= 1'b0;
                end else begin
                    issue_cnt <= issue_cnt + 4'd1;
                end
            end
            if (rd_valid[1]) begin
                capture_cnt <= capture_cnt + 4'd1;
                if (capture_cnt == count_q - 4'd1) begin
                    load_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load_start) begin
            rd_addr <= load_base;
        end else if (issuing && issue_cnt != count_q) begin
            rd_addr <= rd_addr + 8'd1;
        end
    end

    // word arrives two edges after its address was sampled
    always_ff @(posedge CLK) begin
        if (rd_valid[1]) begin
            load_words[capture_cnt] <= cnt_dout;
        end
    end

endmodule

`default_nettype wire

// ==== settings_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module settings_regs
    import ctl_pkg::*;
#(
    parameter int BURST_LEN = MAX_BURST
) (
    input  wire         CLK,
    input  wire         rst,
    input  wire         commit_mod,
    input  wire         commit_silencer,
    input  wire word_t  load_words [BURST_LEN],
    output mod_settings_t      mod_settings,
    output silencer_settings_t silencer_settings
);

    logic mod_pend;
    logic silencer_pend;

    always_ff @(posedge CLK) begin
        if (rst) begin
            mod_settings      <= MOD_DEFAULTS;
            silencer_settings <= SILENCER_DEFAULTS;
            mod_pend          <= 1'b0;
            silencer_pend     <= 1'b0;
        end else begin
            // update trails the field load by one cycle
            mod_pend                 <= commit_mod;
            silencer_pend            <= commit_silencer;
            mod_settings.update      <= mod_pend;
            silencer_settings.update <= silencer_pend;

            if (commit_mod) begin
                mod_settings.req_rd_segment   <= load_words[0][0];
                mod_settings.transition_mode  <= load_words[1][7:0];
                // transition value, lowest word first
                mod_settings.transition_value <= {load_words[5], load_words[4],
                                                  load_words[3], load_words[2]};
                mod_settings.cycle0           <= load_words[6][14:0];
                mod_settings.cycle1           <= load_words[7][14:0];
                mod_settings.freq_div0        <= load_words[8];
                mod_settings.freq_div1        <= load_words[9];
                mod_settings.rep0             <= load_words[10];
                mod_settings.rep1             <= load_words[11];
            end

            if (commit_silencer) begin
                silencer_settings.mode                       <= load_words[0][0];
                silencer_settings.update_rate_intensity      <= load_words[1][7:0];
                silencer_settings.update_rate_phase          <= load_words[2][7:0];
                silencer_settings.completion_steps_intensity <= load_words[3][7:0];
                silencer_settings.completion_steps_phase     <= load_words[4][7:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_controller
    import ctl_pkg::*;
;

    localparam int N_TESTS         = 6;
    localparam int UPDATE_TIMEOUT  = 200;
    localparam int WATCHDOG_CYCLES = N_TESTS * 200 + 200;

    logic               CLK;
    logic               rst;
    logic               thermo;
    logic               mod_segment;
    logic               host_we;
    cnt_addr_t          host_addr;
    word_t              host_wdata;
    word_t              host_rdata;
    mod_settings_t      mod_settings;
    silencer_settings_t silencer_settings;
    logic               force_fan;
    gpio_t              gpio_in;

    logic [31:0] rng_state;
    int          n_checks;
    int          n_errors;

    controller_top dut0 (
        .CLK               (CLK),
        .rst               (rst),
        .thermo            (thermo),
        .mod_segment       (mod_segment),
        .host_we           (host_we),
        .host_addr         (host_addr),
        .host_wdata        (host_wdata),
        .host_rdata        (host_rdata),
        .mod_settings      (mod_settings),
        .silencer_settings (silencer_settings),
        .force_fan         (force_fan),
        .gpio_in           (gpio_in)
    );

    always #4 CLK = ~CLK;

    // xorshift32, one step per call
    function automatic word_t random_word();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x[15:0];
    endfunction

    task automatic host_write(input cnt_addr_t addr, input word_t data);
        @(posedge CLK);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge CLK);
        host_we <= 1'b0;
    endtask

    // two-edge read latency, sampled on the falling edge
    task automatic host_read(input cnt_addr_t addr, output word_t data);
        @(posedge CLK);
        host_addr <= addr;
        @(posedge CLK);
        @(posedge CLK);
        @(negedge CLK);
        data = host_rdata;
    endtask

    task automatic wait_for_mod_update(output bit seen);
        seen = 1'b0;
        for (int i = 0; i < UPDATE_TIMEOUT && !seen; i++) begin
            @(negedge CLK);
            if (mod_settings.update) seen = 1'b1;
        end
    endtask

    task automatic wait_for_silencer_update(output bit seen);
        seen = 1'b0;
        for (int i = 0; i < UPDATE_TIMEOUT && !seen; i++) begin
            @(negedge CLK);
            if (silencer_settings.update) seen = 1'b1;
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (n_errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, n_errors - errs_before);
        end
    endtask

    task automatic test_reset_and_version();
        int    errs;
        word_t rd;
        errs = n_errors;
        @(negedge CLK);
        n_checks++;
        if (mod_settings !== MOD_DEFAULTS || silencer_settings !== SILENCER_DEFAULTS) begin
            $display("FAILED at %0t: settings differ from reset defaults", $time);
            n_errors++;
        end
        n_checks++;
        if (force_fan !== 1'b0 || gpio_in !== 4'h0) begin
            $display("FAILED at %0t: flag outputs not low after reset", $time);
            n_errors++;
        end
        repeat (10) @(posedge CLK);
        host_read(ADDR_VERSION_NUM_MINOR, rd);
        check_word("version minor", rd, 16'h0003);
        host_read(ADDR_VERSION_NUM_MAJOR, rd);
        check_word("version major", rd, 16'h00A5);
        end_test("reset_and_version", errs);
    endtask

    task automatic test_fpga_state();
        int    errs;
        word_t r;
        word_t rd;
        errs = n_errors;
        r = random_word();
        // second pass inverts both inputs so each bit is seen at 0 and 1
        for (int pass = 0; pass < 2; pass++) begin
            @(posedge CLK);
            thermo      <= r[0];
            mod_segment <= r[1];
            repeat (20) @(posedge CLK);
            host_read(ADDR_FPGA_STATE, rd);
            check_word("fpga state", rd, {14'd0, r[1], r[0]});
            r = ~r;
        end
        end_test("fpga_state", errs);
    endtask

    task automatic test_mod_load();
        int            errs;
        word_t         w [MOD_WORDS];
        word_t         rd;
        mod_settings_t exp;
        bit            seen;
        errs = n_errors;
        for (int i = 0; i < MOD_WORDS; i++) begin
            w[i] = random_word();
            host_write(ADDR_MOD_BASE + cnt_addr_t'(i), w[i]);
        end
        exp.update           = 1'b1;
        exp.req_rd_segment   = w[0][0];
        exp.transition_mode  = w[1][7:0];
        exp.transition_value = {w[5], w[4], w[3], w[2]};
        exp.cycle0           = w[6][14:0];
        exp.cycle1           = w[7][14:0];
        exp.freq_div0        = w[8];
        exp.freq_div1        = w[9];
        exp.rep0             = w[10];
        exp.rep1             = w[11];
        host_write(ADDR_CTL_FLAG, 16'h0001);
        wait_for_mod_update(seen);
        n_checks++;
        if (!seen) begin
            $display("Timed out waiting for the modulation update pulse");
            n_errors++;
        end else if (mod_settings !== exp) begin
            $display("FAILED at %0t: mod settings 0x%h, expected 0x%h", $time,
                     mod_settings, exp);
            n_errors++;
        end
        host_read(ADDR_CTL_FLAG, rd);
        check_word("flags after mod load", rd, 16'h0000);
        end_test("mod_load", errs);
    endtask

    task automatic test_silencer_load();
        int                 errs;
        word_t              w [SILENCER_WORDS];
        word_t              rd;
        silencer_settings_t exp;
        bit                 seen;
        errs = n_errors;
        for (int i = 0; i < SILENCER_WORDS; i++) begin
            w[i] = random_word();
            host_write(ADDR_SILENCER_BASE + cnt_addr_t'(i), w[i]);
        end
        exp.update                     = 1'b1;
        exp.mode                       = w[0][0];
        exp.update_rate_intensity      = w[1][7:0];
        exp.update_rate_phase          = w[2][7:0];
        exp.completion_steps_intensity = w[3][7:0];
        exp.completion_steps_phase     = w[4][7:0];
        host_write(ADDR_CTL_FLAG, 16'h0002);
        wait_for_silencer_update(seen);
        n_checks++;
        if (!seen) begin
            $display("Timed out waiting for the silencer update pulse");
            n_errors++;
        end else if (silencer_settings !== exp) begin
            $display("FAILED at %0t: silencer settings 0x%h, expected 0x%h", $time,
                     silencer_settings, exp);
            n_errors++;
        end
        host_read(ADDR_CTL_FLAG, rd);
        check_word("flags after silencer load", rd, 16'h0000);
        end_test("silencer_load", errs);
    endtask

    task automatic test_priority();
        int    errs;
        int    mod_cycle;
        int    sil_cycle;
        word_t rd;
        errs      = n_errors;
        mod_cycle = -1;
        sil_cycle = -1;
        host_write(ADDR_CTL_FLAG, 16'h0003);
        for (int i = 0; i < UPDATE_TIMEOUT && sil_cycle < 0; i++) begin
            @(negedge CLK);
            if (mod_settings.update && mod_cycle < 0) mod_cycle = i;
            if (silencer_settings.update) sil_cycle = i;
        end
        n_checks++;
        if (sil_cycle < 0) begin
            $display("Timed out waiting for the silencer update pulse");
            n_errors++;
        end else if (mod_cycle < 0 || mod_cycle >= sil_cycle) begin
            $display("FAILED at %0t: mod update at cycle %0d not before silencer at %0d",
                     $time, mod_cycle, sil_cycle);
            n_errors++;
        end
        host_read(ADDR_CTL_FLAG, rd);
        check_word("flags after both loads", rd, 16'h0000);
        end_test("priority", errs);
    endtask

    task automatic test_flag_outputs();
        int    errs;
        word_t r;
        word_t flags;
        logic  fan;
        bit    matched;
        errs = n_errors;
        r    = random_word();
        fan  = 1'b1;
        // second pass inverts every bit so each output is seen at 0 and 1
        for (int pass = 0; pass < 2; pass++) begin
            matched = 1'b0;
            flags   = '0;
            flags[CTL_FLAG_BIT_FORCE_FAN] = fan;
            flags[11:8] = r[3:0];
            host_write(ADDR_CTL_FLAG, flags);
            for (int i = 0; i < 20 && !matched; i++) begin
                @(negedge CLK);
                if (force_fan === fan && gpio_in === r[3:0]) matched = 1'b1;
            end
            n_checks++;
            if (!matched) begin
                $display("FAILED at %0t: force_fan %b gpio_in 0x%h, expected %b and 0x%h",
                         $time, force_fan, gpio_in, fan, r[3:0]);
                n_errors++;
            end
            fan = ~fan;
            r   = ~r;
        end
        end_test("flag_outputs", errs);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("Watchdog expired before the tests completed");
        $display("Checks failed");
        $finish;
    end

    initial begin
        CLK         = 1'b0;
        rst         = 1'b1;
        thermo      = 1'b0;
        mod_segment = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        rng_state   = 32'heb409da7;
        n_checks    = 0;
        n_errors    = 0;

        // memory has no reset, so clear the flag word while in reset
        @(posedge CLK);
        host_we    <= 1'b1;
        host_addr  <= ADDR_CTL_FLAG;
        host_wdata <= '0;
        @(posedge CLK);
        host_we <= 1'b0;
        rst     <= 1'b0;

        test_reset_and_version();
        test_fpga_state();
        test_mod_load();
        test_silencer_load();
        test_priority();
        test_flag_outputs();

        $display("tests: %0d, checks: %0d, errors: %0d", N_TESTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
